// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= video_frontend.f
TOP       ?= tb_video_frontend
RTL_TOP   ?= video_frontend
BUILD_DIR ?= obj_dir
PASS_MSG  ?= *** PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_video_frontend.sv ====
`timescale 1ns/1ps

module tb_video_frontend;

    localparam int H_TOTAL       = 40;
    localparam int H_SYNC        = 4;
    localparam int H_BP          = 6;
    localparam int H_ACT         = 24;
    localparam int V_TOTAL       = 20;
    localparam int V_SYNC        = 2;
    localparam int V_BP          = 3;
    localparam int V_ACT         = 12;
    localparam int VS_FALL_X     = 20;
    localparam int FRAMES_EACH   = 3;
    localparam int FRAME_TIMEOUT = 2 * H_TOTAL * V_TOTAL;

    logic                         PCLK_i;
    logic                         rst_n_i;
    video_frontend_pkg::pixel_t   r_i;
    video_frontend_pkg::pixel_t   g_i;
    video_frontend_pkg::pixel_t   b_i;
    logic                         hs_i;
    logic                         vs_i;
    logic                         hsync_pol_i;
    logic                         vsync_pol_i;
    logic                         csc_enable_i;
    video_frontend_pkg::csc_std_e csc_std_i;
    video_frontend_pkg::pixel_t   r_o;
    video_frontend_pkg::pixel_t   g_o;
    video_frontend_pkg::pixel_t   b_o;
    logic                         hsync_o;
    logic                         vsync_o;
    logic                         de_o;
    video_frontend_pkg::vcount_t  xpos_o;
    video_frontend_pkg::vcount_t  ypos_o;
    video_frontend_pkg::vcount_t  lines_total_o;
    logic                         frame_change_o;

    int frame_count;

    video_frontend video_frontend_inst (
        .PCLK_i(PCLK_i), .rst_n_i(rst_n_i),
        .r_i(r_i), .g_i(g_i), .b_i(b_i),
        .hs_i(hs_i), .vs_i(vs_i), .hsync_pol_i(hsync_pol_i), .vsync_pol_i(vsync_pol_i),
        .csc_enable_i(csc_enable_i), .csc_std_i(csc_std_i),
        .h_total_i(12'(H_TOTAL)), .h_active_i(12'(H_ACT)),
        .h_synclen_i(12'(H_SYNC)), .h_backporch_i(12'(H_BP)),
        .v_active_i(11'(V_ACT)), .v_synclen_i(11'(V_SYNC)), .v_backporch_i(11'(V_BP)),
        .r_o(r_o), .g_o(g_o), .b_o(b_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .de_o(de_o),
        .xpos_o(xpos_o), .ypos_o(ypos_o),
        .lines_total_o(lines_total_o), .frame_change_o(frame_change_o)
    );

    bind video_frontend video_frontend_sva video_frontend_sva_inst (.*);

    always #4 PCLK_i = ~PCLK_i;

    always @(posedge PCLK_i or negedge rst_n_i) begin
        if (!rst_n_i)
            frame_count <= 0;
        else if (frame_change_o)
            frame_count <= frame_count + 1;
    end

    // Stop at the first assertion failure
    always @(posedge PCLK_i) begin
        if (video_frontend_inst.video_frontend_sva_inst.error_count != 0) begin
            $display("*** FAILED ***");
            $fatal(1, "An assertion in the checker failed");
        end
    end

    // Hard limit on run length
    initial begin
        #(8 * H_TOTAL * V_TOTAL * 12);
        $display("*** FAILED ***");
        $fatal(1, "Simulation ran past its time limit");
    end

    task automatic next_edge();
        @(posedge PCLK_i);
        #1;
    endtask

    task automatic drive_pixel(input int x, input int y);
        hs_i = (x >= H_SYNC);
        // Vsync falls partway through line 0 and lasts two lines
        vs_i = !((y == 0 && x >= VS_FALL_X) || (y == 1) || (y == 2 && x < VS_FALL_X));
        g_i  = 8'($urandom);
        if ((x + y) % 8 == 3) begin
            r_i = 8'd128;
            b_i = 8'd128;
        end else begin
            r_i = 8'($urandom);
            b_i = 8'($urandom);
        end
    endtask

    task automatic drive_frame();
        for (int y = 0; y < V_TOTAL; y++) begin
            for (int x = 0; x < H_TOTAL; x++) begin
                next_edge();
                drive_pixel(x, y);
            end
        end
    endtask

    task automatic wait_for_frames(input int target);
        int waited;
        waited = 0;
        while (frame_count < target) begin
            if (waited >= FRAME_TIMEOUT) begin
                $display("MISMATCH at %0t: saw %0d frame pulses, expected %0d",
                         $time, frame_count, target);
                $display("*** FAILED ***");
                $fatal(1, "Timed out waiting for a frame pulse");
            end
            next_edge();
            waited++;
        end
    endtask

    initial begin
        PCLK_i       = 1'b0;
        rst_n_i      = 1'b0;
        r_i          = '0;
        g_i          = '0;
        b_i          = '0;
        hs_i         = 1'b1;
        vs_i         = 1'b1;
        hsync_pol_i  = 1'b1;
        vsync_pol_i  = 1'b1;
        csc_enable_i = 1'b0;
        csc_std_i    = video_frontend_pkg::CSC_BT601;
        void'($urandom(32'h66a3d0a2));
        for (int i = 0; i < 16; i++)
            next_edge();
        rst_n_i = 1'b1;

        // Bypass, then BT.601, then BT.709
        for (int mode = 0; mode < 3; mode++) begin
            csc_enable_i = (mode != 0);
            csc_std_i    = (mode == 2) ? video_frontend_pkg::CSC_BT709
                                       : video_frontend_pkg::CSC_BT601;
            for (int f = 0; f < FRAMES_EACH; f++)
                drive_frame();
            wait_for_frames((mode + 1) * FRAMES_EACH);
        end

        // Let the last pixels drain through the pipe
        for (int i = 0; i < 10; i++)
            next_edge();

        if (video_frontend_inst.video_frontend_sva_inst.error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "The checker reported errors");
        end
        $finish;
    end

endmodule

// ==== bench/video_frontend_sva.sv ====
`timescale 1ns/1ps
`include "video_frontend_consts.svh"

module video_frontend_sva (
    input logic                         PCLK_i,
    input logic                         rst_n_i,
    input video_frontend_pkg::pixel_t   r_i,
    input video_frontend_pkg::pixel_t   g_i,
    input video_frontend_pkg::pixel_t   b_i,
    input logic                         hs_i,
    input logic                         vs_i,
    input logic                         hsync_pol_i,
    input logic                         vsync_pol_i,
    input logic                         csc_enable_i,
    input video_frontend_pkg::csc_std_e csc_std_i,
    input video_frontend_pkg::hcount_t  h_total_i,
    input video_frontend_pkg::hcount_t  h_active_i,
    input video_frontend_pkg::hcount_t  h_synclen_i,
    input video_frontend_pkg::pixel_t   r_o,
    input video_frontend_pkg::pixel_t   g_o,
    input video_frontend_pkg::pixel_t   b_o,
    input logic                         hsync_o,
    input logic                         vsync_o,
    input logic                         de_o,
    input video_frontend_pkg::vcount_t  xpos_o,
    input video_frontend_pkg::vcount_t  ypos_o,
    input video_frontend_pkg::vcount_t  lines_total_o,
    input logic                         frame_change_o
);

    localparam int D = `VF_PIPE_DEPTH;

    int error_count = 0;

    video_frontend_pkg::pixel_t   r_h [D];
    video_frontend_pkg::pixel_t   g_h [D];
    video_frontend_pkg::pixel_t   b_h [D];
    logic                         en_h [D];
    video_frontend_pkg::csc_std_e std_h [D];
    video_frontend_pkg::pixel_t   exp_r;
    video_frontend_pkg::pixel_t   exp_g;
    video_frontend_pkg::pixel_t   exp_b;
    int warm;
    int coef_rcr;
    int coef_gcb;
    int coef_gcr;
    int coef_bcb;

    logic hs_n;
    logic vs_n;
    logic hs_q;
    logic vs_q;
    logic line_start;
    logic frame_start;
    logic pending;
    logic fs_q;
    logic seen_line;
    logic hsync_q;
    logic vsync_q;
    logic first_line;
    int   line_len;
    int   line_cnt;
    int   lines_q;
    int   hs_low_cnt;
    int   de_cnt;

    // Offset chroma times coefficient, keeping the 11-bit product slice
    function automatic int chroma_term(input int chroma, input int coef);
        longint prod;
        prod = longint'(chroma - `VF_CHROMA_OFFSET) * longint'(coef);
        return int'((prod >>> `VF_PROD_LSB) & ((1 << (`VF_PROD_MSB - `VF_PROD_LSB + 1)) - 1));
    endfunction

    // 11-bit wrap, then negative to 0 and overflow to 255
    function automatic video_frontend_pkg::pixel_t clamp_channel(input int sum);
        int wrapped;
        wrapped = sum & 'h7FF;
        if (wrapped >= 1024)
            return 8'h00;
        if (wrapped >= 256)
            return 8'hFF;
        return wrapped[7:0];
    endfunction

    always_comb begin
        if (std_h[D-1] == video_frontend_pkg::CSC_BT601) begin
            coef_rcr = int'(`VF_CSC_R_CR_601);
            coef_gcb = int'(`VF_CSC_G_CB_601);
            coef_gcr = int'(`VF_CSC_G_CR_601);
            coef_bcb = int'(`VF_CSC_B_CB_601);
        end else begin
            coef_rcr = int'(`VF_CSC_R_CR_709);
            coef_gcb = int'(`VF_CSC_G_CB_709);
            coef_gcr = int'(`VF_CSC_G_CR_709);
            coef_bcb = int'(`VF_CSC_B_CB_709);
        end
        if (en_h[D-1]) begin
            exp_r = clamp_channel(g_h[D-1] + chroma_term(r_h[D-1], coef_rcr));
            exp_g = clamp_channel(g_h[D-1] - chroma_term(r_h[D-1], coef_gcr)
                                  - chroma_term(b_h[D-1], coef_gcb));
            exp_b = clamp_channel(g_h[D-1] + chroma_term(b_h[D-1], coef_bcb));
        end else begin
            exp_r = r_h[D-1];
            exp_g = g_h[D-1];
            exp_b = b_h[D-1];
        end
    end

    // Input history, the last entry is the pixel now due at the outputs
    always_ff @(posedge PCLK_i) begin
        r_h[0]   <= r_i;
        g_h[0]   <= g_i;
        b_h[0]   <= b_i;
        en_h[0]  <= csc_enable_i;
        std_h[0] <= csc_std_i;
        for (int i = 1; i < D; i++) begin
            r_h[i]   <= r_h[i-1];
            g_h[i]   <= g_h[i-1];
            b_h[i]   <= b_h[i-1];
            en_h[i]  <= en_h[i-1];
            std_h[i] <= std_h[i-1];
        end
    end

    // Reference sync model built from the raw strobes
    assign hs_n        = hsync_pol_i ? hs_i : ~hs_i;
    assign vs_n        = vsync_pol_i ? vs_i : ~vs_i;
    assign line_start  = hs_q & ~hs_n;
    assign frame_start = line_start & pending;

    always_ff @(posedge PCLK_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            warm       <= 0;
            hs_q       <= 1'b0;
            vs_q       <= 1'b0;
            pending    <= 1'b0;
            fs_q       <= 1'b0;
            seen_line  <= 1'b0;
            hsync_q    <= 1'b1;
            vsync_q    <= 1'b1;
            first_line <= 1'b0;
            line_len   <= 0;
            line_cnt   <= 0;
            lines_q    <= 0;
            hs_low_cnt <= 0;
            de_cnt     <= 0;
        end else begin
            if (warm < D + 2)
                warm <= warm + 1;
            hs_q    <= hs_n;
            vs_q    <= vs_n;
            fs_q    <= frame_start;
            hsync_q <= hsync_o;
            vsync_q <= vsync_o;
            if (vs_q && !vs_n)
                pending <= 1'b1;
            else if (frame_start)
                pending <= 1'b0;
            // Output line length, measured between hsync_o falling edges
            if (hsync_q && !hsync_o) begin
                seen_line <= 1'b1;
                line_len  <= 1;
            end else begin
                line_len <= line_len + 1;
            end
            if (frame_start) begin
                lines_q  <= line_cnt;
                line_cnt <= 1;
            end else if (line_start) begin
                line_cnt <= line_cnt + 1;
            end
            hs_low_cnt <= hsync_o ? 0 : hs_low_cnt + 1;
            de_cnt     <= de_o ? de_cnt + 1 : 0;
            if (vsync_q && !vsync_o)
                first_line <= 1'b1;
            else if (de_o)
                first_line <= 1'b0;
        end
    end

    a_pixel: assert property (@(posedge PCLK_i) disable iff (!rst_n_i)
        warm >= D |-> (r_o == exp_r) && (g_o == exp_g) && (b_o == exp_b))
        else begin
            $error("MISMATCH at %0t: rgb %h %h %h, expected %h %h %h",
                   $time, r_o, g_o, b_o, exp_r, exp_g, exp_b);
            error_count++;
        end

    a_gray: assert property (@(posedge PCLK_i) disable iff (!rst_n_i)
        (warm >= D) && en_h[D-1] && (r_h[D-1] == 8'd128) && (b_h[D-1] == 8'd128)
        |-> (r_o == g_h[D-1]) && (g_o == g_h[D-1]) && (b_o == g_h[D-1]))
        else begin
            $error("MISMATCH at %0t: gray input %h did not stay gray", $time, g_h[D-1]);
            error_count++;
        end

    a_line_len: assert property (@(posedge PCLK_i) disable iff (!rst_n_i)
        $fell(hsync_o) && seen_line |-> line_len == int'(h_total_i))
        else begin
            $error("MISMATCH at %0t: output line of %0d clocks", $time, line_len);
            error_count++;
        end

    a_hsync_len: assert property (@(posedge PCLK_i) disable iff (!rst_n_i)
        $rose(hsync_o) |-> hs_low_cnt == int'(h_synclen_i))
        else begin
            $error("MISMATCH at %0t: hsync low for %0d clocks", $time, hs_low_cnt);
            error_count++;
        end

    // Vsync leaves the pipe D-1 cycles after the undelayed frame pulse
    a_vsync_fall: assert property (@(posedge PCLK_i) disable iff (!rst_n_i)
        $fell(vsync_o) == $past(fs_q, D - 1))
        else begin
            $error("MISMATCH at %0t: vsync_o fall not aligned with frame start", $time);
            error_count++;
        end

    a_de_len: assert property (@(posedge PCLK_i) disable iff (!rst_n_i)
        $fell(de_o) |-> de_cnt == int'(h_active_i))
        else begin
            $error("MISMATCH at %0t: de high for %0d clocks", $time, de_cnt);
            error_count++;
        end

    a_xpos: assert property (@(posedge PCLK_i) disable iff (!rst_n_i)
        de_o |-> ($past(de_o) ? xpos_o == $past(xpos_o) + 11'd1 : xpos_o == 11'd0))
        else begin
            $error("MISMATCH at %0t: xpos %0d", $time, xpos_o);
            error_count++;
        end

    a_ypos_first: assert property (@(posedge PCLK_i) disable iff (!rst_n_i)
        $rose(de_o) && first_line |-> ypos_o == 11'd0)
        else begin
            $error("MISMATCH at %0t: first active ypos %0d", $time, ypos_o);
            error_count++;
        end

    a_frame_change: assert property (@(posedge PCLK_i) disable iff (!rst_n_i)
        frame_change_o == fs_q)
        else begin
            $error("MISMATCH at %0t: frame_change %b, expected %b", $time, frame_change_o, fs_q);
            error_count++;
        end

    a_lines_total: assert property (@(posedge PCLK_i) disable iff (!rst_n_i)
        frame_change_o |-> int'(lines_total_o) == lines_q)
        else begin
            $error("MISMATCH at %0t: lines_total %0d, expected %0d", $time, lines_total_o, lines_q);
            error_count++;
        end

endmodule

// ==== verilog/csc_execute.sv ====
`timescale 1ns/1ps
`include "video_frontend_consts.svh"

// Five register stages from r_i to r_o, which is `VF_PIPE_DEPTH
module csc_execute (
    input  logic                         PCLK_i,
    input  logic                         rst_n_i,
    input  video_frontend_pkg::pixel_t   r_i,
    input  video_frontend_pkg::pixel_t   g_i,
    input  video_frontend_pkg::pixel_t   b_i,
    input  logic                         csc_enable_i,
    input  video_frontend_pkg::csc_std_e csc_std_i,
    output video_frontend_pkg::pixel_t   r_o,
    output video_frontend_pkg::pixel_t   g_o,
    output video_frontend_pkg::pixel_t   b_o
);

    // Raw path length up to the final select register
    localparam int RAW_STAGES = 4;

    logic [10:0] y_s1;
    logic [10:0] cb_s1;
    logic [10:0] cr_s1;
    logic [17:0] r_cr_coef;
    logic [17:0] g_cb_coef;
    logic [17:0] g_cr_coef;
    logic [17:0] b_cb_coef;

    logic signed [35:0] r_cr_prod;
    logic signed [35:0] g_cb_prod;
    logic signed [35:0] g_cr_prod;
    logic signed [35:0] b_cb_prod;
    logic [10:0]        y_s2;

    logic [10:0] r_cr_s3;
    logic [10:0] g_cb_s3;
    logic [10:0] g_cr_s3;
    logic [10:0] b_cb_s3;
    logic [10:0] y_s3;

    logic [10:0] r_sum;
    logic [10:0] g_sum;
    logic [10:0] b_sum;

    video_frontend_pkg::pixel_t r_csc;
    video_frontend_pkg::pixel_t g_csc;
    video_frontend_pkg::pixel_t b_csc;

    video_frontend_pkg::pixel_t r_dly [RAW_STAGES];
    video_frontend_pkg::pixel_t g_dly [RAW_STAGES];
    video_frontend_pkg::pixel_t b_dly [RAW_STAGES];
    logic [RAW_STAGES-1:0]      en_dly;

    // Bit 10 set means negative, bits 9:8 set means 256 or more
    function automatic video_frontend_pkg::pixel_t clamp_sum(input logic [10:0] sum);
        if (sum[10])
            return 8'h00;
        else if (|sum[9:8])
            return 8'hFF;
        else
            return sum[7:0];
    endfunction

    assign r_sum = y_s3 + r_cr_s3;
    assign g_sum = y_s3 - g_cr_s3 - g_cb_s3;
    assign b_sum = y_s3 + b_cb_s3;

    always_ff @(posedge PCLK_i) begin
        // Stage 1: offset removal and coefficient select
        y_s1  <= {3'b000, g_i};
        cb_s1 <= {3'b000, b_i} - 11'(`VF_CHROMA_OFFSET);
        cr_s1 <= {3'b000, r_i} - 11'(`VF_CHROMA_OFFSET);
        if (csc_std_i == video_frontend_pkg::CSC_BT601) begin
            r_cr_coef <= `VF_CSC_R_CR_601;
            g_cb_coef <= `VF_CSC_G_CB_601;
            g_cr_coef <= `VF_CSC_G_CR_601;
            b_cb_coef <= `VF_CSC_B_CB_601;
        end else begin
            r_cr_coef <= `VF_CSC_R_CR_709;
            g_cb_coef <= `VF_CSC_G_CB_709;
            g_cr_coef <= `VF_CSC_G_CR_709;
            b_cb_coef <= `VF_CSC_B_CB_709;
        end

        // Stage 2: signed products, chroma sign extended to 18 bits
        r_cr_prod <= $signed({{7{cr_s1[10]}}, cr_s1}) * $signed(r_cr_coef);
        g_cb_prod <= $signed({{7{cb_s1[10]}}, cb_s1}) * $signed(g_cb_coef);
        g_cr_prod <= $signed({{7{cr_s1[10]}}, cr_s1}) * $signed(g_cr_coef);
        b_cb_prod <= $signed({{7{cb_s1[10]}}, cb_s1}) * $signed(b_cb_coef);
        y_s2      <= y_s1;

        // Stage 3
        r_cr_s3 <= r_cr_prod[`VF_PROD_MSB:`VF_PROD_LSB];
        g_cb_s3 <= g_cb_prod[`VF_PROD_MSB:`VF_PROD_LSB];
        g_cr_s3 <= g_cr_prod[`VF_PROD_MSB:`VF_PROD_LSB];
        b_cb_s3 <= b_cb_prod[`VF_PROD_MSB:`VF_PROD_LSB];
        y_s3    <= y_s2;

        // Stage 4: sum and clamp to 8 bits
        r_csc <= clamp_sum(r_sum);
        g_csc <= clamp_sum(g_sum);
        b_csc <= clamp_sum(b_sum);

        // Raw data runs alongside so bypass has the same latency
        r_dly[0] <= r_i;
        g_dly[0] <= g_i;
        b_dly[0] <= b_i;
        for (int i = 1; i < RAW_STAGES; i++) begin
            r_dly[i] <= r_dly[i-1];
            g_dly[i] <= g_dly[i-1];
            b_dly[i] <= b_dly[i-1];
        end

        // Stage 5 is the output register
        r_o <= en_dly[RAW_STAGES-1] ? r_csc : r_dly[RAW_STAGES-1];
        g_o <= en_dly[RAW_STAGES-1] ? g_csc : g_dly[RAW_STAGES-1];
        b_o <= en_dly[RAW_STAGES-1] ? b_csc : b_dly[RAW_STAGES-1];
    end

    // Enable follows its pixel down the pipe
    always_ff @(posedge PCLK_i or negedge rst_n_i) begin
        if (!rst_n_i)
            en_dly <= '0;
        else
            en_dly <= {en_dly[RAW_STAGES-2:0], csc_enable_i};
    end

endmodule

// ==== verilog/sync_timing_decode.sv ====
`timescale 1ns/1ps

module sync_timing_decode (
    input  logic                        PCLK_i,
    input  logic                        rst_n_i,
    input  logic                        hs_i,
    input  logic                        vs_i,
    input  logic                        hsync_pol_i,
    input  logic                        vsync_pol_i,
    input  video_frontend_pkg::hcount_t h_synclen_i,
    input  video_frontend_pkg::hcount_t h_backporch_i,
    input  video_frontend_pkg::hcount_t h_active_i,
    input  video_frontend_pkg::vcount_t v_synclen_i,
    input  video_frontend_pkg::vcount_t v_backporch_i,
    input  video_frontend_pkg::vcount_t v_active_i,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        de_o,
    output video_frontend_pkg::vcount_t xpos_o,
    output video_frontend_pkg::vcount_t ypos_o,
    output logic                        frame_change_o,
    output video_frontend_pkg::vcount_t lines_total_o
);

    video_frontend_pkg::hcount_t h_cnt;
    video_frontend_pkg::vcount_t v_cnt;

    logic hs_np;
    logic vs_np;
    logic hs_np_q;
    logic vs_np_q;
    logic line_start;
    logic vs_fall;
    logic vs_pending;
    logic frame_start;

    video_frontend_pkg::hcount_t h_start;
    video_frontend_pkg::hcount_t h_end;
    video_frontend_pkg::hcount_t x_diff;
    video_frontend_pkg::vcount_t v_start;
    video_frontend_pkg::vcount_t v_end;
    logic                        h_in_window;
    logic                        v_in_window;

    // Normalized strobes, the leading edge is the falling one
    assign hs_np = hs_i ^ ~hsync_pol_i;
    assign vs_np = vs_i ^ ~vsync_pol_i;

    assign line_start  = hs_np_q & ~hs_np;
    assign vs_fall     = vs_np_q & ~vs_np;
    assign frame_start = line_start & vs_pending;

    // Active window starts after sync plus back porch
    assign h_start = h_synclen_i + h_backporch_i;
    assign h_end   = h_start + h_active_i;
    assign v_start = v_synclen_i + v_backporch_i;
    assign v_end   = v_start + v_active_i;

    assign h_in_window = (h_cnt >= h_start) && (h_cnt < h_end);
    assign v_in_window = (v_cnt >= v_start) && (v_cnt < v_end);
    assign x_diff      = h_cnt - h_start;

    always_ff @(posedge PCLK_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hs_np_q        <= 1'b0;
            vs_np_q        <= 1'b0;
            vs_pending     <= 1'b0;
            h_cnt          <= '0;
            v_cnt          <= '0;
            hsync_o        <= 1'b1;
            vsync_o        <= 1'b1;
            de_o           <= 1'b0;
            frame_change_o <= 1'b0;
            lines_total_o  <= '0;
        end else begin
            hs_np_q        <= hs_np;
            vs_np_q        <= vs_np;
            frame_change_o <= frame_start;
            de_o           <= h_in_window & v_in_window;

            if (line_start) begin
                h_cnt   <= '0;
                hsync_o <= 1'b0;
                if (frame_start) begin
                    // Vsync is only seen a line late, so the count restarts at 1
                    v_cnt         <= 11'd1;
                    lines_total_o <= v_cnt;
                    vsync_o       <= 1'b0;
                end else begin
                    v_cnt <= v_cnt + 11'd1;
                    if (v_cnt == v_synclen_i - 11'd1)
                        vsync_o <= 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 12'd1;
                if (h_cnt == h_synclen_i - 12'd1)
                    hsync_o <= 1'b1;
            end

            // Armed by vsync and consumed by the next line start
            if (vs_fall)
                vs_pending <= 1'b1;
            else if (frame_start)
                vs_pending <= 1'b0;
        end
    end

    // Positions relative to the first active pixel and line
    always_ff @(posedge PCLK_i) begin
        xpos_o <= x_diff[10:0];
        ypos_o <= v_cnt - v_start;
    end

endmodule

// ==== verilog/timing_align_result.sv ====
`timescale 1ns/1ps
`include "video_frontend_consts.svh"

module timing_align_result (
    input  logic                        PCLK_i,
    input  logic                        rst_n_i,
    input  logic                        hsync_i,
    input  logic                        vsync_i,
    input  logic                        de_i,
    input  video_frontend_pkg::vcount_t xpos_i,
    input  video_frontend_pkg::vcount_t ypos_i,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        de_o,
    output video_frontend_pkg::vcount_t xpos_o,
    output video_frontend_pkg::vcount_t ypos_o
);

    // Decode already holds the first pipeline stage
    localparam int STAGES = `VF_PIPE_DEPTH - 1;

    logic [STAGES-1:0]           hsync_sr;
    logic [STAGES-1:0]           vsync_sr;
    logic [STAGES-1:0]           de_sr;
    video_frontend_pkg::vcount_t xpos_sr [STAGES];
    video_frontend_pkg::vcount_t ypos_sr [STAGES];

    // Syncs idle high and DE low until real timing shifts through
    always_ff @(posedge PCLK_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hsync_sr <= '1;
            vsync_sr <= '1;
            de_sr    <= '0;
        end else begin
            hsync_sr <= {hsync_sr[STAGES-2:0], hsync_i};
            vsync_sr <= {vsync_sr[STAGES-2:0], vsync_i};
            de_sr    <= {de_sr[STAGES-2:0], de_i};
        end
    end

    always_ff @(posedge PCLK_i) begin
        xpos_sr[0] <= xpos_i;
        ypos_sr[0] <= ypos_i;
        for (int i = 1; i < STAGES; i++) begin
            xpos_sr[i] <= xpos_sr[i-1];
            ypos_sr[i] <= ypos_sr[i-1];
        end
    end

    // Last stage is the output register
    assign hsync_o = hsync_sr[STAGES-1];
    assign vsync_o = vsync_sr[STAGES-1];
    assign de_o    = de_sr[STAGES-1];
    assign xpos_o  = xpos_sr[STAGES-1];
    assign ypos_o  = ypos_sr[STAGES-1];

endmodule

// ==== verilog/video_frontend.sv ====
`timescale 1ns/1ps

module video_frontend (
    input  logic                         PCLK_i,
    input  logic                         rst_n_i,
    input  video_frontend_pkg::pixel_t   r_i,
    input  video_frontend_pkg::pixel_t   g_i,
    input  video_frontend_pkg::pixel_t   b_i,
    input  logic                         hs_i,
    input  logic                         vs_i,
    input  logic                         hsync_pol_i,
    input  logic                         vsync_pol_i,
    input  logic                         csc_enable_i,
    input  video_frontend_pkg::csc_std_e csc_std_i,
    // Line length follows hs_i, h_total_i is kept for config compatibility
    input  video_frontend_pkg::hcount_t  h_total_i,
    input  video_frontend_pkg::hcount_t  h_active_i,
    input  video_frontend_pkg::hcount_t  h_synclen_i,
    input  video_frontend_pkg::hcount_t  h_backporch_i,
    input  video_frontend_pkg::vcount_t  v_active_i,
    input  video_frontend_pkg::vcount_t  v_synclen_i,
    input  video_frontend_pkg::vcount_t  v_backporch_i,
    output video_frontend_pkg::pixel_t   r_o,
    output video_frontend_pkg::pixel_t   g_o,
    output video_frontend_pkg::pixel_t   b_o,
    output logic                         hsync_o,
    output logic                         vsync_o,
    output logic                         de_o,
    output video_frontend_pkg::vcount_t  xpos_o,
    output video_frontend_pkg::vcount_t  ypos_o,
    output video_frontend_pkg::vcount_t  lines_total_o,
    output logic                         frame_change_o
);

    // Stage 1 timing from the decoder
    logic                        hsync_s1;
    logic                        vsync_s1;
    logic                        de_s1;
    video_frontend_pkg::vcount_t xpos_s1;
    video_frontend_pkg::vcount_t ypos_s1;

    sync_timing_decode sync_timing_decode_inst (
        .PCLK_i         (PCLK_i),
        .rst_n_i        (rst_n_i),
        .hs_i           (hs_i),
        .vs_i           (vs_i),
        .hsync_pol_i    (hsync_pol_i),
        .vsync_pol_i    (vsync_pol_i),
        .h_synclen_i    (h_synclen_i),
        .h_backporch_i  (h_backporch_i),
        .h_active_i     (h_active_i),
        .v_synclen_i    (v_synclen_i),
        .v_backporch_i  (v_backporch_i),
        .v_active_i     (v_active_i),
        .hsync_o        (hsync_s1),
        .vsync_o        (vsync_s1),
        .de_o           (de_s1),
        .xpos_o         (xpos_s1),
        .ypos_o         (ypos_s1),
        .frame_change_o (frame_change_o),
        .lines_total_o  (lines_total_o)
    );

    csc_execute csc_execute_inst (
        .PCLK_i       (PCLK_i),
        .rst_n_i      (rst_n_i),
        .r_i          (r_i),
        .g_i          (g_i),
        .b_i          (b_i),
        .csc_enable_i (csc_enable_i),
        .csc_std_i    (csc_std_i),
        .r_o          (r_o),
        .g_o          (g_o),
        .b_o          (b_o)
    );

    timing_align_result timing_align_result_inst (
        .PCLK_i  (PCLK_i),
        .rst_n_i (rst_n_i),
        .hsync_i (hsync_s1),
        .vsync_i (vsync_s1),
        .de_i    (de_s1),
        .xpos_i  (xpos_s1),
        .ypos_i  (ypos_s1),
        .hsync_o (hsync_o),
        .vsync_o (vsync_o),
        .de_o    (de_o),
        .xpos_o  (xpos_o),
        .ypos_o  (ypos_o)
    );

endmodule

// ==== verilog/video_frontend_consts.svh ====
`ifndef VIDEO_FRONTEND_CONSTS_SVH
`define VIDEO_FRONTEND_CONSTS_SVH

// Pixel path latency in PCLK cycles from input port to output port
`define VF_PIPE_DEPTH 5

// BT.601 YCbCr to RGB coefficients
// Unsigned 18-bit fixed point with 15 fractional bits
`define VF_CSC_R_CR_601 18'h0B395
`define VF_CSC_G_CB_601 18'h02C08
`define VF_CSC_G_CR_601 18'h05B64
`define VF_CSC_B_CB_601 18'h0E2F1

// BT.709 YCbCr to RGB coefficients
// Same fixed point format as BT.601
`define VF_CSC_R_CR_709 18'h0C8F9
`define VF_CSC_G_CB_709 18'h017EF
`define VF_CSC_G_CR_709 18'h03BB2
`define VF_CSC_B_CB_709 18'h0ED84

// Zero level of the Cb and Cr channels
`define VF_CHROMA_OFFSET 128

// Slice of the 36-bit product that is kept
// Drops the 15 fraction bits and leaves an 11-bit signed term
`define VF_PROD_MSB 25
`define VF_PROD_LSB 15

`endif

// ==== verilog/video_frontend_pkg.sv ====
package video_frontend_pkg;

    // One colour channel sample, 8 bits per channel
    typedef logic [7:0] pixel_t;

    // Horizontal counter width
    // Also used for the horizontal timing configuration values
    typedef logic [11:0] hcount_t;

    // Vertical counter width
    // Line positions and vertical timing configuration use it too
    typedef logic [10:0] vcount_t;

    // Colour standard for the YCbCr to RGB matrix
    typedef enum logic {
        CSC_BT601 = 1'b0,
        CSC_BT709 = 1'b1
    } csc_std_e;

endpackage

// ==== video_frontend.f ====
+incdir+verilog
verilog/video_frontend_pkg.sv
verilog/sync_timing_decode.sv
verilog/csc_execute.sv
verilog/timing_align_result.sv
verilog/video_frontend.sv
bench/video_frontend_sva.sv
bench/tb_video_frontend.sv
